// File: Makefile
SIM      := verilator
SIMFLAGS := --binary --timing --assert -Wno-fatal
TOP      := icache_tb
FILELIST := filelist.f
OBJDIR   := obj_dir
LOG      := sim.log
PASS_MSG := Finished with no errors
FAIL_MSG := Finished with errors

.PHONY: sim clean

sim:
	$(SIM) $(SIMFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJDIR)
	./$(OBJDIR)/V$(TOP) 2>&1 | tee $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then echo "Simulation failed"; exit 1; fi
	@if ! grep -q "$(PASS_MSG)" $(LOG); then echo "Simulation did not complete"; exit 1; fi
	@echo "Simulation passed"

clean:
	rm -rf $(OBJDIR) $(LOG)

// File: filelist.f
src/icache_geom_pkg.sv
src/icache_ctrl_pkg.sv
src/lru_if.sv
src/cache_dpram.sv
src/cache_lru.sv
src/icache.sv
src/icache_top.sv
verif/icache_tb.sv

// File: src/cache_dpram.sv
`timescale 1ns/1ps

module cache_dpram #(
   parameter int DEPTH_WIDTH = 4,
   parameter int DATA_WIDTH  = 32
) (
   input  logic                   clk,
   input  logic [DEPTH_WIDTH-1:0] raddr_i,
   input  logic [DEPTH_WIDTH-1:0] waddr_i,
   input  logic                   we_i,
   input  logic [DATA_WIDTH-1:0]  din_i,
   output logic [DATA_WIDTH-1:0]  dout_o
);

   // Storage array
   logic [DATA_WIDTH-1:0] mem [0:(1 << DEPTH_WIDTH)-1];

   // Write port
   always_ff @(posedge clk) begin
      if (we_i) begin
         mem[waddr_i] <= din_i;
      end
   end

   // Registered read port
   // A same-address write in this cycle is not seen until the next read
   always_ff @(posedge clk) begin
      dout_o <= mem[raddr_i];
   end

endmodule

// File: src/cache_lru.sv
`timescale 1ns/1ps

module cache_lru (
   lru_if.unit lru
);
   import icache_geom_pkg::*;

   // History with the access applied
   logic [LRU_WIDTH-1:0] hist_next;
   // Way that lost every pairwise comparison
   logic [NUM_WAYS-1:0]  lru_way;

   // Bit position of pair (i, j) with i < j
   // Pairs are numbered (0,1) (0,2) .. (0,N-1) (1,2) .. (N-2,N-1)
   function automatic int pair_idx(input int i, input int j);
      return i * NUM_WAYS - (i * (i + 1)) / 2 + (j - i - 1);
   endfunction

   always_comb begin
      hist_next = lru.current;
      lru_way   = '1;
      for (int i = 0; i < NUM_WAYS - 1; i++) begin
         for (int j = i + 1; j < NUM_WAYS; j++) begin
            // Set bit means way i was used after way j
            if (lru.current[pair_idx(i, j)]) begin
               lru_way[i] = 1'b0;
            end else begin
               lru_way[j] = 1'b0;
            end

            // Accessed way becomes the newer one of each of its pairs
            if (lru.access[i]) begin
               hist_next[pair_idx(i, j)] = 1'b1;
            end else if (lru.access[j]) begin
               hist_next[pair_idx(i, j)] = 1'b0;
            end
         end
      end
   end

   assign lru.update  = hist_next;
   assign lru.lru_pre = lru_way;

   // The controller touches one way at most
   // Several set bits would leave the history inconsistent
   always_comb begin
      assert ($onehot0(lru.access))
         else $error("cache_lru: access vector %b is not one-hot", lru.access);
   end

endmodule

// File: src/icache.sv
`timescale 1ns/1ps

module icache (
   input  logic                                       clk,
   input  logic                                       rst_n_i,

   // CPU fetch side
   input  logic                                       cpu_req_i,
   input  logic [icache_geom_pkg::ADDR_WIDTH-1:0]     cpu_adr_i,
   output logic                                       cpu_ack_o,
   output logic                                       cpu_err_o,
   output logic [icache_ctrl_pkg::DATA_WIDTH-1:0]     cpu_dat_o,

   // Refill bus
   input  logic                                       ibus_ack_i,
   input  logic                                       ibus_err_i,
   input  logic [icache_ctrl_pkg::DATA_WIDTH-1:0]     ibus_dat_i,
   output logic                                       ibus_req_o,
   output logic [icache_geom_pkg::ADDR_WIDTH-1:0]     ibus_adr_o,

   // SPR write port
   input  logic                                       spr_stb_i,
   input  logic                                       spr_we_i,
   input  logic [icache_ctrl_pkg::SPR_ADDR_WIDTH-1:0] spr_addr_i,
   input  logic [icache_ctrl_pkg::DATA_WIDTH-1:0]     spr_dat_i,
   output logic                                       spr_ack_o
);
   import icache_geom_pkg::*;
   import icache_ctrl_pkg::*;

   icache_state_e state;

   // Lookup address, walks the line in refill, holds the invalidate target
   logic [ADDR_WIDTH-1:0] adr_r;
   logic [SET_WIDTH-1:0]  adr_set;
   logic [TAG_WIDTH-1:0]  adr_tag;

   // Refill progress
   logic [BLOCK_WIDTH-3:0] beat_cnt;
   logic                   first_beat;
   logic                   last_beat;
   logic                   beat_ok;
   logic                   miss_ack_r;
   logic [DATA_WIDTH-1:0]  miss_dat_r;

   // Snapshot of the missed set
   logic [NUM_WAYS-1:0]                        victim_r;
   logic [NUM_WAYS-1:0][TAGMEM_WAY_WIDTH-1:0]  way_save_r;
   logic [LRU_WIDTH-1:0]                       hist_save_r;

   // Reset sweep over all sets
   logic                 sweep_r;
   logic [SET_WIDTH-1:0] sweep_idx;

   logic inv_req;
   logic start_inv;
   logic start_read;

   // Tag RAM
   logic [SET_WIDTH-1:0]                       tag_raddr;
   logic [SET_WIDTH-1:0]                       tag_waddr;
   logic                                       tag_we;
   logic [TAGMEM_WIDTH-1:0]                    tag_dout;
   logic [TAGMEM_WIDTH-1:0]                    tag_din;
   logic [NUM_WAYS-1:0][TAGMEM_WAY_WIDTH-1:0]  tag_way_out;
   logic [NUM_WAYS-1:0][TAGMEM_WAY_WIDTH-1:0]  tag_way_in;
   logic [LRU_WIDTH-1:0]                       tag_lru_out;
   logic [LRU_WIDTH-1:0]                       tag_lru_in;

   // Way RAMs
   logic [WORD_ADDR_WIDTH-1:0]           way_raddr;
   logic [WORD_ADDR_WIDTH-1:0]           way_waddr;
   logic [NUM_WAYS-1:0]                  way_we;
   logic [NUM_WAYS-1:0][DATA_WIDTH-1:0]  way_dout;

   logic [NUM_WAYS-1:0]  way_hit;
   logic                 hit;
   logic [DATA_WIDTH-1:0] hit_dat;
   logic [NUM_WAYS-1:0]  access;

   lru_if lru ();

   assign adr_set = adr_r[WAY_WIDTH-1:BLOCK_WIDTH];
   assign adr_tag = adr_r[ADDR_WIDTH-1:WAY_WIDTH];

   // Lookups read straight from the CPU address
   assign tag_raddr = cpu_adr_i[WAY_WIDTH-1:BLOCK_WIDTH];
   assign way_raddr = cpu_adr_i[WAY_WIDTH-1:2];
   assign way_waddr = adr_r[WAY_WIDTH-1:2];
   assign tag_waddr = sweep_r ? sweep_idx : adr_set;

   // Split the tag entry
   assign tag_way_out = tag_dout[NUM_WAYS*TAGMEM_WAY_WIDTH-1:0];
   assign tag_lru_out = tag_dout[TAGMEM_WIDTH-1 -: LRU_WIDTH];
   assign tag_din     = {tag_lru_in, tag_way_in};

   // Valid and tag match per way
   always_comb begin
      for (int w = 0; w < NUM_WAYS; w++) begin
         way_hit[w] = tag_way_out[w][TAGMEM_WAY_WIDTH-1] &&
                      (tag_way_out[w][TAG_WIDTH-1:0] == adr_tag);
      end
   end

   assign hit = |way_hit;

   // Data of the hitting way
   always_comb begin
      hit_dat = '0;
      for (int w = 0; w < NUM_WAYS; w++) begin
         if (way_hit[w]) begin
            hit_dat = hit_dat | way_dout[w];
         end
      end
   end

   assign first_beat = (beat_cnt == '0);
   assign last_beat  = (beat_cnt == (BLOCK_WIDTH-2)'(WORDS_PER_LINE - 1));
   assign beat_ok    = (state == ST_REFILL) && ibus_ack_i && !ibus_err_i;

   // Invalidate has priority over a fetch, both wait for the sweep
   assign inv_req    = spr_stb_i && spr_we_i && (spr_addr_i == SPR_ICBIR_ADDR);
   assign start_inv  = (state == ST_IDLE) && !sweep_r && inv_req;
   assign start_read = (state == ST_IDLE) && !sweep_r && !inv_req && cpu_req_i;

   // Hit acks straight from the RAM output, a miss from the captured beat
   assign cpu_ack_o  = ((state == ST_READ) && hit) || miss_ack_r;
   assign cpu_dat_o  = (state == ST_READ) ? hit_dat : miss_dat_r;
   // Only the missed word belongs to the CPU, later errors just abort the fill
   assign cpu_err_o  = (state == ST_REFILL) && ibus_err_i && first_beat;
   assign ibus_req_o = (state == ST_REFILL);
   assign ibus_adr_o = adr_r;

   // History source is the saved one while refilling
   assign lru.current = (state == ST_REFILL) ? hist_save_r : tag_lru_out;
   assign lru.access  = access;

   // Tag and way write control
   always_comb begin
      tag_way_in = way_save_r;
      tag_lru_in = hist_save_r;
      tag_we     = 1'b0;
      way_we     = '0;
      access     = '0;
      if (sweep_r) begin
         tag_way_in = '0;
         tag_lru_in = '0;
         tag_we     = 1'b1;
      end else begin
         case (state)
            ST_READ: begin
               if (hit) begin
                  // Refresh history of the hit way
                  access     = way_hit;
                  tag_way_in = tag_way_out;
                  tag_lru_in = lru.update;
                  tag_we     = 1'b1;
               end
            end
            ST_REFILL: begin
               access = victim_r;
               if (beat_ok) begin
                  way_we = victim_r;
                  // Victim invalid until the whole line is in
                  if (first_beat) begin
                     for (int w = 0; w < NUM_WAYS; w++) begin
                        if (victim_r[w]) begin
                           tag_way_in[w][TAGMEM_WAY_WIDTH-1] = 1'b0;
                        end
                     end
                     tag_we = 1'b1;
                  end
                  // Line complete, publish new tag and history
                  if (last_beat) begin
                     for (int w = 0; w < NUM_WAYS; w++) begin
                        if (victim_r[w]) begin
                           tag_way_in[w] = {1'b1, adr_tag};
                        end
                     end
                     tag_lru_in = lru.update;
                     tag_we     = 1'b1;
                  end
               end
            end
            ST_INVALIDATE: begin
               tag_way_in = '0;
               tag_lru_in = '0;
               tag_we     = 1'b1;
            end
            default: begin
            end
         endcase
      end
   end

   // Controller FSM
   always_ff @(posedge clk or negedge rst_n_i) begin
      if (!rst_n_i) begin
         state      <= ST_IDLE;
         beat_cnt   <= '0;
         miss_ack_r <= 1'b0;
         spr_ack_o  <= 1'b0;
         sweep_r    <= 1'b1;
         sweep_idx  <= '0;
      end else begin
         miss_ack_r <= 1'b0;
         spr_ack_o  <= 1'b0;
         // One set per cycle after reset
         if (sweep_r) begin
            sweep_idx <= sweep_idx + 1'b1;
            if (&sweep_idx) begin
               sweep_r <= 1'b0;
            end
         end
         case (state)
            ST_IDLE: begin
               if (start_inv) begin
                  state     <= ST_INVALIDATE;
                  spr_ack_o <= 1'b1;
               end else if (start_read) begin
                  state <= ST_READ;
               end
            end
            ST_READ: begin
               beat_cnt <= '0;
               state    <= hit ? ST_IDLE : ST_REFILL;
            end
            ST_REFILL: begin
               if (ibus_err_i) begin
                  state <= ST_IDLE;
               end else if (ibus_ack_i) begin
                  beat_cnt <= beat_cnt + 1'b1;
                  // Refill starts at the missed word
                  miss_ack_r <= first_beat;
                  if (last_beat) begin
                     state <= ST_IDLE;
                  end
               end
            end
            ST_INVALIDATE: begin
               state <= ST_IDLE;
            end
            default: begin
               state <= ST_IDLE;
            end
         endcase
      end
   end

   // Address and miss snapshot
   always_ff @(posedge clk) begin
      if (start_read) begin
         adr_r <= cpu_adr_i;
      end else if (start_inv) begin
         adr_r <= spr_dat_i;
      end else if (beat_ok) begin
         // Next word, wraps inside the line
         adr_r[BLOCK_WIDTH-1:2] <= adr_r[BLOCK_WIDTH-1:2] + 1'b1;
      end
      if ((state == ST_READ) && !hit) begin
         victim_r    <= lru.lru_pre;
         way_save_r  <= tag_way_out;
         hist_save_r <= tag_lru_out;
      end
      if (beat_ok && first_beat) begin
         miss_dat_r <= ibus_dat_i;
      end
   end

   // Tag RAM, one entry per set
   cache_dpram #(
      .DEPTH_WIDTH(SET_WIDTH),
      .DATA_WIDTH (TAGMEM_WIDTH)
   ) u_tag_ram (
      .clk    (clk),
      .raddr_i(tag_raddr),
      .waddr_i(tag_waddr),
      .we_i   (tag_we),
      .din_i  (tag_din),
      .dout_o (tag_dout)
   );

   // Data RAM per way
   for (genvar g = 0; g < NUM_WAYS; g++) begin : g_way
      cache_dpram #(
         .DEPTH_WIDTH(WORD_ADDR_WIDTH),
         .DATA_WIDTH (DATA_WIDTH)
      ) u_way_ram (
         .clk    (clk),
         .raddr_i(way_raddr),
         .waddr_i(way_waddr),
         .we_i   (way_we[g]),
         .din_i  (ibus_dat_i),
         .dout_o (way_dout[g])
      );
   end

   cache_lru u_lru (
      .lru(lru)
   );

   // Refill never leaves a tag stored twice in one set
   a_way_hit_onehot : assert property (@(posedge clk) disable iff (!rst_n_i)
      (state == ST_READ) |-> $onehot0(way_hit))
      else $error("icache: several ways hit in set %0d", adr_set);

   // Bus address waits for the beat to be acknowledged
   a_ibus_adr_stable : assert property (@(posedge clk) disable iff (!rst_n_i)
      (ibus_req_o && !ibus_ack_i) |=> $stable(ibus_adr_o))
      else $error("icache: ibus_adr_o changed without ibus_ack_i");

endmodule

// File: src/icache_ctrl_pkg.sv
package icache_ctrl_pkg;

   // Instruction and bus word
   localparam int DATA_WIDTH = 32;

   // SPR register numbers are 16 bits
   localparam int SPR_ADDR_WIDTH = 16;

   // Block invalidate register, data is a byte address in the set
   localparam logic [SPR_ADDR_WIDTH-1:0] SPR_ICBIR_ADDR = 16'h2002;

   // Controller FSM
   typedef enum logic [1:0] {
      ST_IDLE,
      ST_READ,
      ST_REFILL,
      ST_INVALIDATE
   } icache_state_e;

endpackage

// File: src/icache_geom_pkg.sv
package icache_geom_pkg;

   // Byte address as seen by the CPU and by the refill bus
   localparam int ADDR_WIDTH = 32;

   // 16-byte lines, four words each
   localparam int BLOCK_WIDTH = 4;

   // 16 sets
   localparam int SET_WIDTH = 4;

   localparam int NUM_WAYS = 4;

   // Bytes covered by one way
   localparam int WAY_WIDTH = BLOCK_WIDTH + SET_WIDTH;

   // Word address into a single way RAM
   localparam int WORD_ADDR_WIDTH = WAY_WIDTH - 2;

   localparam int WORDS_PER_LINE = 1 << (BLOCK_WIDTH - 2);

   // Tag is everything left of the set index
   localparam int TAG_WIDTH = ADDR_WIDTH - WAY_WIDTH;

   // Valid flag sits on top of the tag
   localparam int TAGMEM_WAY_WIDTH = TAG_WIDTH + 1;

   // One history bit per pair of ways
   localparam int LRU_WIDTH = (NUM_WAYS * (NUM_WAYS - 1)) >> 1;

   // Tag RAM entry, from the top:
   //   LRU history | way 3 valid+tag | ... | way 0 valid+tag
   localparam int TAGMEM_WIDTH = TAGMEM_WAY_WIDTH * NUM_WAYS + LRU_WIDTH;

endpackage

// File: src/icache_top.sv
`timescale 1ns/1ps

module icache_top (
   input  logic                                       clk,
   input  logic                                       rst_n_i,

   // CPU fetch side
   input  logic                                       cpu_req_i,
   input  logic [icache_geom_pkg::ADDR_WIDTH-1:0]     cpu_adr_i,
   output logic                                       cpu_ack_o,
   output logic                                       cpu_err_o,
   output logic [icache_ctrl_pkg::DATA_WIDTH-1:0]     cpu_dat_o,

   // Refill bus
   input  logic                                       ibus_ack_i,
   input  logic                                       ibus_err_i,
   input  logic [icache_ctrl_pkg::DATA_WIDTH-1:0]     ibus_dat_i,
   output logic                                       ibus_req_o,
   output logic [icache_geom_pkg::ADDR_WIDTH-1:0]     ibus_adr_o,

   // SPR write port
   input  logic                                       spr_stb_i,
   input  logic                                       spr_we_i,
   input  logic [icache_ctrl_pkg::SPR_ADDR_WIDTH-1:0] spr_addr_i,
   input  logic [icache_ctrl_pkg::DATA_WIDTH-1:0]     spr_dat_i,
   output logic                                       spr_ack_o
);

   // Cache controller with its RAMs and LRU unit
   icache u_icache (
      .clk       (clk),
      .rst_n_i   (rst_n_i),
      .cpu_req_i (cpu_req_i),
      .cpu_adr_i (cpu_adr_i),
      .cpu_ack_o (cpu_ack_o),
      .cpu_err_o (cpu_err_o),
      .cpu_dat_o (cpu_dat_o),
      .ibus_ack_i(ibus_ack_i),
      .ibus_err_i(ibus_err_i),
      .ibus_dat_i(ibus_dat_i),
      .ibus_req_o(ibus_req_o),
      .ibus_adr_o(ibus_adr_o),
      .spr_stb_i (spr_stb_i),
      .spr_we_i  (spr_we_i),
      .spr_addr_i(spr_addr_i),
      .spr_dat_i (spr_dat_i),
      .spr_ack_o (spr_ack_o)
   );

endmodule

// File: src/lru_if.sv
`timescale 1ns/1ps

interface lru_if;
   import icache_geom_pkg::*;

   // History as stored in the tag entry
   logic [LRU_WIDTH-1:0] current;
   // One-hot way touched in this cycle, zero for none
   logic [NUM_WAYS-1:0]  access;
   // History after the access
   logic [LRU_WIDTH-1:0] update;
   // One-hot least recently used way before the access
   logic [NUM_WAYS-1:0]  lru_pre;

   // Cache controller side
   modport ctrl (output current, output access, input update, input lru_pre);

   // LRU unit side
   modport unit (input current, input access, output update, output lru_pre);

endinterface

// File: verif/icache_tb.sv
`timescale 1ns/1ps

module icache_tb;
   import icache_geom_pkg::*;
   import icache_ctrl_pkg::*;

   localparam int NUM_SETS  = 1 << SET_WIDTH;
   localparam int NUM_LINES = 12;
   // Memory returns its own address scrambled with this key
   localparam logic [DATA_WIDTH-1:0] MEM_KEY = 32'h5a5a_0f0f;
   // The two sets that all test lines map into
   localparam logic [SET_WIDTH-1:0] SET_A = 4'd3;
   localparam logic [SET_WIDTH-1:0] SET_B = 4'd9;
   localparam int FETCH_TIMEOUT = 64;
   localparam int SPR_TIMEOUT   = 32;

   logic                      clk;
   logic                      rst_n;
   logic                      cpu_req;
   logic [ADDR_WIDTH-1:0]     cpu_adr;
   logic                      cpu_ack;
   logic                      cpu_err;
   logic [DATA_WIDTH-1:0]     cpu_dat;
   logic                      ibus_ack;
   logic                      ibus_err;
   logic [DATA_WIDTH-1:0]     ibus_dat;
   logic                      ibus_req;
   logic [ADDR_WIDTH-1:0]     ibus_adr;
   logic                      spr_stb;
   logic                      spr_we;
   logic [SPR_ADDR_WIDTH-1:0] spr_addr;
   logic [DATA_WIDTH-1:0]     spr_dat;
   logic                      spr_ack;

   integer seed = 32'hdecd_5ab1;

   // Bus memory state
   int                    bus_delay = 0;
   bit                    err_pending = 1'b0;
   logic [ADDR_WIDTH-1:0] bus_log [$];

   // Reference cache, age 0 is the least recently used way
   logic [TAG_WIDTH-1:0] m_tag   [NUM_SETS][NUM_WAYS];
   bit                   m_valid [NUM_SETS][NUM_WAYS];
   int                   m_age   [NUM_SETS][NUM_WAYS];

   logic [ADDR_WIDTH-1:0] line_base [NUM_LINES];

   icache_top dut_i (
      .clk       (clk),
      .rst_n_i   (rst_n),
      .cpu_req_i (cpu_req),
      .cpu_adr_i (cpu_adr),
      .cpu_ack_o (cpu_ack),
      .cpu_err_o (cpu_err),
      .cpu_dat_o (cpu_dat),
      .ibus_ack_i(ibus_ack),
      .ibus_err_i(ibus_err),
      .ibus_dat_i(ibus_dat),
      .ibus_req_o(ibus_req),
      .ibus_adr_o(ibus_adr),
      .spr_stb_i (spr_stb),
      .spr_we_i  (spr_we),
      .spr_addr_i(spr_addr),
      .spr_dat_i (spr_dat),
      .spr_ack_o (spr_ack)
   );

   always #50 clk = ~clk;

   // Bus memory with 0 to 3 idle cycles before each beat
   always @(negedge clk) begin
      ibus_ack = 1'b0;
      ibus_err = 1'b0;
      if (ibus_req) begin
         if (bus_delay == 0) begin
            if (err_pending) begin
               ibus_err    = 1'b1;
               err_pending = 1'b0;
            end else begin
               ibus_ack = 1'b1;
               ibus_dat = ibus_adr ^ MEM_KEY;
               bus_log.push_back(ibus_adr);
            end
            bus_delay = $random(seed) & 32'h3;
         end else begin
            bus_delay = bus_delay - 1;
         end
      end
   end

   task automatic abort_run();
      $display("Finished with errors");
      $fatal(1, "run aborted");
   endtask

   task automatic check_value(input string name, input logic [31:0] got,
                              input logic [31:0] exp);
      if (got !== exp) begin
         $display("mismatch at %0t: %s got %h expected %h", $time, name, got, exp);
         abort_run();
      end
   endtask

   task automatic report_timeout(input string what);
      $display("timeout at %0t: %s", $time, what);
      abort_run();
   endtask

   // Empty set, history back to way 0 oldest
   function automatic void model_clear_set(input int s);
      int w;
      for (w = 0; w < NUM_WAYS; w++) begin
         m_valid[s][w] = 1'b0;
         m_age[s][w]   = w;
      end
   endfunction

   // Way becomes the most recently used one
   function automatic void model_touch(input int s, input int w);
      int v;
      for (v = 0; v < NUM_WAYS; v++) begin
         if (m_age[s][v] > m_age[s][w]) begin
            m_age[s][v] = m_age[s][v] - 1;
         end
      end
      m_age[s][w] = NUM_WAYS - 1;
   endfunction

   // Hitting way or -1
   function automatic int model_find(input logic [ADDR_WIDTH-1:0] adr);
      int s;
      int w;
      int found;
      s     = int'(adr[WAY_WIDTH-1:BLOCK_WIDTH]);
      found = -1;
      for (w = 0; w < NUM_WAYS; w++) begin
         if (m_valid[s][w] && (m_tag[s][w] == adr[ADDR_WIDTH-1:WAY_WIDTH])) begin
            found = w;
         end
      end
      return found;
   endfunction

   function automatic int model_oldest(input int s);
      int w;
      int oldest;
      oldest = 0;
      for (w = 0; w < NUM_WAYS; w++) begin
         if (m_age[s][w] == 0) begin
            oldest = w;
         end
      end
      return oldest;
   endfunction

   function automatic logic [ADDR_WIDTH-1:0] word_addr(input int line, input int word);
      return line_base[line] + ADDR_WIDTH'(word * 4);
   endfunction

   // One fetch, checked against the model, returns once the DUT is idle again
   task automatic fetch(input logic [ADDR_WIDTH-1:0] adr, input bit inject_err,
                        output bit was_hit);
      int                    s;
      int                    way;
      int                    k;
      int                    cycles;
      int                    ack_cycles;
      bit                    got_ack;
      bit                    got_err;
      bit                    saw_req;
      logic [DATA_WIDTH-1:0] dat;
      logic [ADDR_WIDTH-1:0] exp_adr;
      s           = int'(adr[WAY_WIDTH-1:BLOCK_WIDTH]);
      way         = model_find(adr);
      was_hit     = (way >= 0);
      err_pending = inject_err;
      bus_log.delete();
      cpu_req = 1'b1;
      cpu_adr = adr;
      // Request cycle counts as the first one
      cycles     = 1;
      ack_cycles = 0;
      got_ack    = 1'b0;
      got_err    = 1'b0;
      saw_req    = 1'b0;
      dat        = '0;
      // Sample in the low phase, after the bus model has driven its beat
      while (!got_ack && !got_err) begin
         @(negedge clk);
         #1;
         cycles = cycles + 1;
         if (ibus_req) begin
            saw_req = 1'b1;
         end
         if (cpu_ack) begin
            got_ack    = 1'b1;
            ack_cycles = cycles;
            dat        = cpu_dat;
         end
         if (cpu_err) begin
            got_err = 1'b1;
         end
         if (!got_ack && !got_err && (cycles >= FETCH_TIMEOUT)) begin
            report_timeout("fetch got neither cpu_ack_o nor cpu_err_o");
         end
      end
      @(negedge clk);
      cpu_req = 1'b0;
      // Rest of the line still streams in after the ack
      cycles = 0;
      while (ibus_req) begin
         if (cycles >= FETCH_TIMEOUT) begin
            report_timeout("refill did not finish the line");
         end
         @(negedge clk);
         cycles = cycles + 1;
      end
      check_value("cpu_err_o", 32'(got_err), 32'(inject_err));
      check_value("cpu_ack_o", 32'(got_ack), 32'(!inject_err));
      check_value("ibus_req_o", 32'(saw_req), 32'(!was_hit));
      if (got_ack) begin
         check_value("cpu_dat_o", dat, adr ^ MEM_KEY);
      end
      if (was_hit) begin
         // Request cycle plus lookup cycle
         check_value("hit latency", 32'(ack_cycles), 32'(2));
         model_touch(s, way);
      end else if (!inject_err) begin
         // Critical word first, then wrap inside the line
         check_value("refill beats", 32'(bus_log.size()), 32'(WORDS_PER_LINE));
         for (k = 0; k < WORDS_PER_LINE; k++) begin
            exp_adr = {adr[ADDR_WIDTH-1:BLOCK_WIDTH],
                       (BLOCK_WIDTH-2)'(int'(adr[BLOCK_WIDTH-1:2]) + k), 2'b00};
            check_value("ibus_adr_o", bus_log[k], exp_adr);
         end
         way = model_oldest(s);
         m_tag[s][way]   = adr[ADDR_WIDTH-1:WAY_WIDTH];
         m_valid[s][way] = 1'b1;
         model_touch(s, way);
      end
   endtask

   // Block invalidate through the SPR port
   task automatic invalidate(input logic [ADDR_WIDTH-1:0] adr);
      int cycles;
      bit got;
      spr_stb  = 1'b1;
      spr_we   = 1'b1;
      spr_addr = SPR_ICBIR_ADDR;
      spr_dat  = adr;
      cycles   = 0;
      got      = 1'b0;
      while (!got) begin
         @(negedge clk);
         cycles = cycles + 1;
         if (spr_ack) begin
            got = 1'b1;
         end else if (cycles >= SPR_TIMEOUT) begin
            report_timeout("spr_ack_o did not come for the invalidate");
         end
      end
      @(negedge clk);
      spr_stb = 1'b0;
      spr_we  = 1'b0;
      model_clear_set(int'(adr[WAY_WIDTH-1:BLOCK_WIDTH]));
   endtask

   initial begin
      int k;
      int n;
      int pick;
      bit hit;
      clk      = 1'b0;
      rst_n    = 1'b0;
      cpu_req  = 1'b0;
      cpu_adr  = '0;
      ibus_ack = 1'b0;
      ibus_err = 1'b0;
      ibus_dat = '0;
      spr_stb  = 1'b0;
      spr_we   = 1'b0;
      spr_addr = '0;
      spr_dat  = '0;
      // Six lines per set, distinct tags
      for (k = 0; k < NUM_LINES; k++) begin
         line_base[k] = {8'h0a, 8'(k), 8'(k * 29), (k < 6) ? SET_A : SET_B, 4'h0};
      end
      for (k = 0; k < NUM_SETS; k++) begin
         model_clear_set(k);
      end
      repeat (5) @(posedge clk);
      @(negedge clk);
      rst_n = 1'b1;

      // Cold miss starting in the middle of the line
      fetch(word_addr(6, 2), 1'b0, hit);
      check_value("cache hit", 32'(hit), 32'(0));

      // Whole line now resident
      for (k = 0; k < WORDS_PER_LINE; k++) begin
         fetch(word_addr(6, k), 1'b0, hit);
         check_value("cache hit", 32'(hit), 32'(1));
      end

      // Five lines into one set, line 0 gets evicted
      for (k = 0; k < 5; k++) begin
         fetch(word_addr(k, k % WORDS_PER_LINE), 1'b0, hit);
         check_value("cache hit", 32'(hit), 32'(0));
      end
      fetch(word_addr(0, 1), 1'b0, hit);
      check_value("cache hit", 32'(hit), 32'(0));
      for (k = 2; k < 5; k++) begin
         fetch(word_addr(k, 3), 1'b0, hit);
         check_value("cache hit", 32'(hit), 32'(1));
      end

      // Invalidate set A, set B keeps its line
      invalidate(line_base[2]);
      fetch(word_addr(0, 0), 1'b0, hit);
      check_value("cache hit", 32'(hit), 32'(0));
      for (k = 2; k < 5; k++) begin
         fetch(word_addr(k, 1), 1'b0, hit);
         check_value("cache hit", 32'(hit), 32'(0));
      end
      fetch(word_addr(6, 3), 1'b0, hit);
      check_value("cache hit", 32'(hit), 32'(1));

      // Bus error on the missed word, then a clean retry
      fetch(word_addr(7, 1), 1'b1, hit);
      check_value("cache hit", 32'(hit), 32'(0));
      fetch(word_addr(7, 1), 1'b0, hit);
      check_value("cache hit", 32'(hit), 32'(0));

      // Random fetches with the odd invalidate
      for (n = 0; n < 400; n++) begin
         pick = $random(seed) & 32'hf;
         k    = ($random(seed) & 32'h7fff_ffff) % NUM_LINES;
         if (pick == 0) begin
            invalidate(word_addr(k, $random(seed) & 32'h3));
         end else begin
            fetch(word_addr(k, $random(seed) & 32'h3), 1'b0, hit);
         end
      end

      $display("Finished with no errors");
      $finish;
   end

endmodule
